/* Makefile */
# Verilator lint and simulation for the logic-link read slave

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := tb_llink_slave
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+common
common/llink_pkg.sv
llink_rx/llink_rx_fifo.sv
llink_tx/llink_tx_credit.sv
rtl/llink_phy_pack.sv
rtl/llink_slave_top.sv
tb/llink_slave_checker.sv
tb/tb_llink_slave.sv

/* common/llink_consts.svh */
// Logic-link read slave constants for bus widths, FIFO depth and credit size
`ifndef LLINK_CONSTS_SVH
`define LLINK_CONSTS_SVH

////////////////////////////////////////////////////////////
// AXI field widths

// Read data beat width
`define LLINK_DATA_W 64

// Read address width
`define LLINK_ADDR_W 48

// Transaction ID width
`define LLINK_ID_W 4

////////////////////////////////////////////////////////////
// Link flow control

// Requests held in the AR receive FIFO
`define LLINK_AR_DEPTH 8

// Transmit credit counter width
`define LLINK_CRED_W 8

`endif

/* common/llink_pkg.sv */
// Logic-link read slave types for AXI payloads and PHY word layouts
`include "llink_consts.svh"

package llink_pkg;

  // AXI burst encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // Transmit side link state
  typedef enum logic {
    LINK_DOWN = 1'b0,
    LINK_UP   = 1'b1
  } link_state_e;

  ////////////////////////////////////////////////////////////
  // AXI payloads

  typedef struct packed {
    logic [`LLINK_ID_W-1:0]   id;
    logic [`LLINK_ADDR_W-1:0] addr;
    logic [7:0]               len;
    logic [2:0]               size;
    axi_burst_e               burst;
  } ar_req_t;

  typedef struct packed {
    logic [`LLINK_ID_W-1:0]   id;
    logic [`LLINK_DATA_W-1:0] data;
    logic [1:0]               resp;
    logic                     last;
  } r_beat_t;

  ////////////////////////////////////////////////////////////
  // PHY lane words

  // Far side to slave
  typedef struct packed {
    logic    ar_push;
    ar_req_t ar;
    logic    r_credit;
  } phy_rx_word_t;

  // Slave to far side
  typedef struct packed {
    logic    r_push;
    r_beat_t r;
    logic    ar_credit;
  } phy_tx_word_t;

endpackage

/* llink_rx/llink_rx_fifo.sv */
// AR receive FIFO that buffers far-side requests and returns one credit per pop
`timescale 1ns/10ps
`include "llink_consts.svh"

module llink_rx_fifo (
  input  logic              clk_wr,
  input  logic              rst,
  input  logic              rx_online,
  input  logic              tx_online,
  input  logic              ar_push,
  input  llink_pkg::ar_req_t ar_in,
  output llink_pkg::ar_req_t ar_req,
  output logic              ar_valid,
  input  logic              ar_ready,
  output logic              ar_credit
);

  import llink_pkg::*;

  localparam int DEPTH = `LLINK_AR_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;

  ar_req_t            mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               full;
  logic               wr_en;
  logic               rd_en;

  // Wraps at DEPTH so non power of two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign ar_valid = (count != '0);
  assign ar_req   = mem[rd_ptr];

  // Far side must respect credits, so a push when full is dropped
  assign wr_en = ar_push && rx_online && !full;
  assign rd_en = ar_valid && ar_ready;

  ////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= ar_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // One credit back to the far side per request taken
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ar_credit <= 1'b0;
    end else begin
      ar_credit <= rd_en && tx_online;
    end
  end

endmodule

/* llink_tx/llink_tx_credit.sv */
// R transmit gate with link state machine and far-side credit counter
`timescale 1ns/10ps
`include "llink_consts.svh"

module llink_tx_credit (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     tx_online,
  input  logic [`LLINK_CRED_W-1:0] init_r_credit,
  input  logic                     r_credit,
  input  llink_pkg::r_beat_t       r_beat,
  input  logic                     r_valid,
  output logic                     r_ready,
  output logic                     r_push,
  output llink_pkg::r_beat_t       r_out
);

  import llink_pkg::*;

  localparam int CRED_W = `LLINK_CRED_W;

  link_state_e        state;
  link_state_e        state_nxt;
  logic [CRED_W-1:0]  credit_cnt;
  logic [CRED_W-1:0]  credit_nxt;
  logic               r_xfer;
  logic               cnt_max;

  ////////////////////////////////////////////////////////////
  // User side gate

  // Ready only with the link up and at least one credit left
  assign r_ready = (state == LINK_UP) && (credit_cnt != '0);
  assign r_xfer  = r_valid && r_ready;

  // Beat goes straight to the framer in the transfer cycle
  assign r_push = r_xfer;
  assign r_out  = r_beat;

  assign cnt_max = (credit_cnt == {CRED_W{1'b1}});

  ////////////////////////////////////////////////////////////
  // Link state and credit count

  always_comb begin
    state_nxt  = state;
    credit_nxt = credit_cnt;
    case (state)
      LINK_DOWN: begin
        if (tx_online) begin
          state_nxt  = LINK_UP;
          credit_nxt = init_r_credit;
        end
      end
      LINK_UP: begin
        if (!tx_online) begin
          state_nxt  = LINK_DOWN;
          credit_nxt = '0;
        end else if (r_xfer && !r_credit) begin
          credit_nxt = credit_cnt - CRED_W'(1);
        end else if (!r_xfer && r_credit && !cnt_max) begin
          // Saturate rather than wrap to zero
          credit_nxt = credit_cnt + CRED_W'(1);
        end
      end
      default: begin
        state_nxt  = LINK_DOWN;
        credit_nxt = '0;
      end
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state      <= LINK_DOWN;
      credit_cnt <= '0;
    end else begin
      state      <= state_nxt;
      credit_cnt <= credit_nxt;
    end
  end

endmodule

/* rtl/llink_phy_pack.sv */
// PHY framer that splits the received word and registers the transmitted word
`timescale 1ns/10ps

module llink_phy_pack (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  llink_pkg::phy_rx_word_t rx_phy,
  output llink_pkg::phy_tx_word_t tx_phy,
  output logic                    ar_push,
  output llink_pkg::ar_req_t      ar_in,
  output logic                    r_credit,
  input  logic                    r_push,
  input  llink_pkg::r_beat_t      r_out,
  input  logic                    ar_credit
);

  import llink_pkg::*;

  phy_tx_word_t tx_nxt;
  r_beat_t      r_lane;

  ////////////////////////////////////////////////////////////
  // Receive side

  // No pipeline stage here, the FIFO samples these directly
  assign ar_push  = rx_phy.ar_push;
  assign ar_in    = rx_phy.ar;
  assign r_credit = rx_phy.r_credit;

  ////////////////////////////////////////////////////////////
  // Transmit side

  // Idle lane carries an all zero beat
  always_comb begin
    if (r_push) begin
      r_lane = r_out;
    end else begin
      r_lane = '0;
    end
  end

  always_comb begin
    tx_nxt.r_push    = r_push;
    tx_nxt.r         = r_lane;
    tx_nxt.ar_credit = ar_credit;
  end

  // Whole word is cleared in reset so the far side sees a quiet lane
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_nxt;
    end
  end

endmodule

/* rtl/llink_slave_top.sv */
// Logic-link AXI read slave top joining receive FIFO, transmit gate and PHY framer
`timescale 1ns/10ps
`include "llink_consts.svh"

module llink_slave_top (
  input  logic                     clk_wr,
  input  logic                     rst,

  // Link control
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [`LLINK_CRED_W-1:0] init_r_credit,

  // PHY lane
  input  llink_pkg::phy_rx_word_t  rx_phy,
  output llink_pkg::phy_tx_word_t  tx_phy,

  // AR channel
  output llink_pkg::ar_req_t       ar_req,
  output logic                     ar_valid,
  input  logic                     ar_ready,

  // R channel
  input  llink_pkg::r_beat_t       r_beat,
  input  logic                     r_valid,
  output logic                     r_ready
);

  import llink_pkg::*;

  ////////////////////////////////////////////////////////////
  // Block interconnect

  logic     ar_push;
  ar_req_t  ar_in;
  logic     ar_credit;
  logic     r_credit;
  logic     r_push;
  r_beat_t  r_out;

  llink_rx_fifo u_rx_fifo (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .rx_online (rx_online),
    .tx_online (tx_online),
    .ar_push   (ar_push),
    .ar_in     (ar_in),
    .ar_req    (ar_req),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar_credit (ar_credit)
  );

  llink_tx_credit u_tx_credit (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online     (tx_online),
    .init_r_credit (init_r_credit),
    .r_credit      (r_credit),
    .r_beat        (r_beat),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .r_push        (r_push),
    .r_out         (r_out)
  );

  llink_phy_pack u_phy_pack (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .rx_phy    (rx_phy),
    .tx_phy    (tx_phy),
    .ar_push   (ar_push),
    .ar_in     (ar_in),
    .r_credit  (r_credit),
    .r_push    (r_push),
    .r_out     (r_out),
    .ar_credit (ar_credit)
  );

endmodule

/* tb/llink_slave_checker.sv */
// Bound assertions on the logic-link read slave handshakes and flow control
`timescale 1ns/10ps
`include "llink_consts.svh"

module llink_slave_checker (
  input logic                     clk_wr,
  input logic                     rst,
  input logic                     rx_online,
  input llink_pkg::phy_rx_word_t  rx_phy,
  input llink_pkg::ar_req_t       ar_req,
  input logic                     ar_valid,
  input logic                     ar_ready,
  input logic                     r_valid,
  input logic                     r_ready,
  input logic                     fifo_full,
  input logic [`LLINK_CRED_W-1:0] credit_cnt
);

  // AR payload holds while the user stalls
  ar_hold: assert property (@(posedge clk_wr) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_req))
    else $error("AR valid or payload changed while ar_ready was low");

  // Far side keeps to its credits
  no_push_full: assert property (@(posedge clk_wr) disable iff (rst)
    rx_phy.ar_push && rx_online |-> !fifo_full)
    else $error("AR push arrived with the receive FIFO full");

  // Spending the last credit with none coming back closes the R path
  r_gate: assert property (@(posedge clk_wr) disable iff (rst)
    r_valid && r_ready && !rx_phy.r_credit && (credit_cnt == 1)
      |=> (credit_cnt == '0) && !r_ready)
    else $error("r_ready high after the last transmit credit was used");

  // Quiet user side right after reset
  reset_quiet: assert property (@(posedge clk_wr)
    rst |=> !ar_valid && !r_ready)
    else $error("ar_valid or r_ready high in the cycle after reset");

endmodule

bind llink_slave_top llink_slave_checker u_checker (
  .clk_wr     (clk_wr),
  .rst        (rst),
  .rx_online  (rx_online),
  .rx_phy     (rx_phy),
  .ar_req     (ar_req),
  .ar_valid   (ar_valid),
  .ar_ready   (ar_ready),
  .r_valid    (r_valid),
  .r_ready    (r_ready),
  .fifo_full  (u_rx_fifo.full),
  .credit_cnt (u_tx_credit.credit_cnt)
);

/* tb/tb_llink_slave.sv */
// Directed testbench for the logic-link AXI read slave
`timescale 1ns/10ps
`include "llink_consts.svh"

module tb_llink_slave;

  import llink_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DEPTH       = `LLINK_AR_DEPTH;
  localparam int ID_W        = `LLINK_ID_W;
  localparam int ADDR_W      = `LLINK_ADDR_W;
  localparam int DATA_W      = `LLINK_DATA_W;
  localparam int CRED_W      = `LLINK_CRED_W;
  localparam int AR_REQS     = 20;
  localparam int AR_MAX      = 200;
  localparam int FRAME_BEATS = 12;
  localparam int FRAME_MAX   = 40;
  // Reset, link restarts, FIFO fill and R tests on top of the two long loops
  localparam int TEST_CYCLES = 9 + 5 * 4 + AR_MAX + 6 * DEPTH + 30 + FRAME_MAX + 16;
  localparam int MARGIN      = 100;

  logic              clk_wr;
  logic              rst;
  logic              tx_online;
  logic              rx_online;
  logic [CRED_W-1:0] init_r_credit;
  phy_rx_word_t      rx_phy;
  phy_tx_word_t      tx_phy;
  ar_req_t           ar_req;
  logic              ar_valid;
  logic              ar_ready;
  r_beat_t           r_beat;
  logic              r_valid;
  logic              r_ready;

  // Scoreboard state
  ar_req_t    ar_exp_q[$];
  r_beat_t    r_src_q[$];
  logic [1:0] cred_pipe;
  logic       r_prev_xfer;
  r_beat_t    r_prev_beat;
  logic       r_xfer_now;
  int         ar_xfers;
  int         ar_credits;
  int         r_xfers;

  llink_slave_top u_llink_slave_top (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .init_r_credit (init_r_credit),
    .rx_phy        (rx_phy),
    .tx_phy        (tx_phy),
    .ar_req        (ar_req),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r_beat        (r_beat),
    .r_valid       (r_valid),
    .r_ready       (r_ready)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "first error ends the run");
  endtask

  task automatic check_ar(input ar_req_t got, input ar_req_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_r(input r_beat_t got, input r_beat_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic ar_req_t rand_ar();
    ar_req_t req;
    req.id    = ID_W'($urandom);
    req.addr  = ADDR_W'({$urandom, $urandom});
    req.len   = 8'($urandom);
    req.size  = 3'($urandom_range(0, 3));
    req.burst = axi_burst_e'(2'($urandom_range(0, 2)));
    return req;
  endfunction

  function automatic r_beat_t rand_beat();
    r_beat_t beat;
    beat.id   = ID_W'($urandom);
    beat.data = DATA_W'({$urandom, $urandom});
    beat.resp = 2'($urandom);
    beat.last = ($urandom_range(0, 1) == 1);
    return beat;
  endfunction

  task automatic drive_rx(input logic push, input ar_req_t req, input logic credit);
    phy_rx_word_t word;
    word.ar_push  = push;
    word.ar       = req;
    word.r_credit = credit;
    rx_phy <= word;
  endtask

  // Monitor at the falling edge, where every output has settled
  task automatic sample_cycle();
    logic    ar_xfer;
    r_beat_t exp_r;
    @(negedge clk_wr);
    ar_xfer = ar_valid && ar_ready;
    if (ar_xfer) begin
      if (ar_exp_q.size() == 0) begin
        $display("AR request handed out at %0t ns with none outstanding", $time);
        stop_run();
      end else begin
        check_ar(ar_req, ar_exp_q.pop_front(), "ar_req");
        ar_xfers++;
      end
    end
    // Credit shows two cycles after the pop
    check_bit(tx_phy.ar_credit, cred_pipe[1], "tx_phy.ar_credit");
    if (tx_phy.ar_credit) begin
      ar_credits++;
    end
    cred_pipe = {cred_pipe[0], ar_xfer && tx_online};
    // Framed beat one cycle after its transfer, zero when idle
    exp_r = '0;
    if (r_prev_xfer) begin
      exp_r = r_prev_beat;
    end
    check_bit(tx_phy.r_push, r_prev_xfer, "tx_phy.r_push");
    check_r(tx_phy.r, exp_r, "tx_phy.r");
    r_xfer_now  = r_valid && r_ready;
    r_prev_xfer = r_xfer_now;
    r_prev_beat = r_beat;
    if (r_xfer_now) begin
      r_xfers++;
    end
  endtask

  // Offers queued beats and holds each one until it is taken
  task automatic offer_r(input int cycles, input int pulses, input bit gaps);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_wr);
      drive_rx(1'b0, '0, i < pulses);
      if (r_xfer_now && r_src_q.size() != 0) begin
        void'(r_src_q.pop_front());
      end
      if (!r_valid || r_xfer_now) begin
        if (r_src_q.size() != 0 && (!gaps || $urandom_range(0, 2) != 0)) begin
          r_valid <= 1'b1;
          r_beat  <= r_src_q[0];
        end else begin
          r_valid <= 1'b0;
        end
      end
      sample_cycle();
    end
  endtask

  task automatic restart_link(input logic [CRED_W-1:0] credit);
    @(posedge clk_wr);
    tx_online <= 1'b0;
    sample_cycle();
    @(posedge clk_wr);
    sample_cycle();
    check_bit(r_ready, 1'b0, "r_ready with link down");
    @(posedge clk_wr);
    tx_online     <= 1'b1;
    init_r_credit <= credit;
    sample_cycle();
    @(posedge clk_wr);
    sample_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests

  task automatic reset_values();
    check_bit(ar_valid, 1'b0, "ar_valid after reset");
    check_bit(r_ready, 1'b0, "r_ready after reset");
    check_bit(tx_phy == '0, 1'b1, "tx_phy all zero after reset");
  endtask

  task automatic ar_pass_through();
    int      pushed;
    int      base;
    int      cbase;
    ar_req_t req;
    pushed = 0;
    base   = ar_xfers;
    cbase  = ar_credits;
    for (int i = 0; i < AR_MAX && (pushed < AR_REQS || ar_exp_q.size() != 0); i++) begin
      @(posedge clk_wr);
      ar_ready <= ($urandom_range(0, 3) != 0);
      if (pushed < AR_REQS && pushed - (ar_xfers - base) < DEPTH &&
          $urandom_range(0, 1) == 1) begin
        req = rand_ar();
        ar_exp_q.push_back(req);
        drive_rx(1'b1, req, 1'b0);
        pushed++;
      end else begin
        drive_rx(1'b0, '0, 1'b0);
      end
      sample_cycle();
    end
    if (ar_exp_q.size() != 0) begin
      $display("AR pass-through did not drain, %0d requests left", ar_exp_q.size());
      stop_run();
    end
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_wr);
      drive_rx(1'b0, '0, 1'b0);
      sample_cycle();
    end
    check_bit(ar_credits - cbase == AR_REQS, 1'b1, "one ar_credit per AR transfer");
  endtask

  task automatic ar_fifo_fill();
    ar_req_t req;
    for (int i = 0; i < DEPTH + 4; i++) begin
      @(posedge clk_wr);
      ar_ready <= 1'b0;
      if (i < DEPTH) begin
        req = rand_ar();
        ar_exp_q.push_back(req);
        drive_rx(1'b1, req, 1'b0);
      end else begin
        drive_rx(1'b0, '0, 1'b0);
      end
      sample_cycle();
    end
    check_bit(ar_valid, 1'b1, "ar_valid with FIFO full");
    for (int i = 0; i < 4 * DEPTH && ar_exp_q.size() != 0; i++) begin
      @(posedge clk_wr);
      ar_ready <= 1'b1;
      sample_cycle();
    end
    if (ar_exp_q.size() != 0) begin
      $display("Full AR FIFO did not drain, %0d requests left", ar_exp_q.size());
      stop_run();
    end
    // Pushes with the receive side offline are dropped
    for (int i = 0; i < 6; i++) begin
      @(posedge clk_wr);
      rx_online <= 1'b0;
      drive_rx(i < 4, rand_ar(), 1'b0);
      sample_cycle();
      check_bit(ar_valid, 1'b0, "ar_valid with rx_online low");
    end
    @(posedge clk_wr);
    rx_online <= 1'b1;
    sample_cycle();
  endtask

  task automatic r_credit_limit();
    int base;
    restart_link(CRED_W'(3));
    base = r_xfers;
    for (int i = 0; i < 5; i++) begin
      r_src_q.push_back(rand_beat());
    end
    offer_r(8, 0, 1'b0);
    check_bit(r_xfers - base == 3, 1'b1, "three beats taken on initial credit");
    check_bit(r_ready, 1'b0, "r_ready with credit used up");
    offer_r(8, 2, 1'b0);
    check_bit(r_xfers - base == 5, 1'b1, "two more beats after two credits");
    check_bit(r_ready, 1'b0, "r_ready after returned credit used");
  endtask

  task automatic r_framing();
    restart_link(CRED_W'(FRAME_BEATS + 8));
    for (int i = 0; i < FRAME_BEATS; i++) begin
      r_src_q.push_back(rand_beat());
    end
    offer_r(FRAME_MAX, 0, 1'b1);
    check_bit(r_src_q.size() == 0, 1'b1, "all framed beats accepted");
  endtask

  task automatic link_down_reload();
    int base;
    restart_link(CRED_W'(5));
    check_bit(r_ready, 1'b1, "r_ready with link up");
    restart_link(CRED_W'(2));
    base = r_xfers;
    for (int i = 0; i < 4; i++) begin
      r_src_q.push_back(rand_beat());
    end
    offer_r(8, 0, 1'b0);
    check_bit(r_xfers - base == 2, 1'b1, "beats taken after credit reload");
    check_bit(r_ready, 1'b0, "r_ready after reloaded credit used");
    r_src_q.delete();
    @(posedge clk_wr);
    r_valid <= 1'b0;
    sample_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'h4c94_3841));
    rst           = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b1;
    init_r_credit = '0;
    rx_phy        = '0;
    ar_ready      = 1'b0;
    r_beat        = '0;
    r_valid       = 1'b0;
    cred_pipe     = '0;
    r_prev_xfer   = 1'b0;
    r_prev_beat   = '0;
    r_xfer_now    = 1'b0;
    ar_xfers      = 0;
    ar_credits    = 0;
    r_xfers       = 0;
    repeat (8) @(posedge clk_wr);
    rst <= 1'b0;
    sample_cycle();
    reset_values();
    restart_link('0);
    ar_pass_through();
    ar_fifo_fill();
    r_credit_limit();
    r_framing();
    link_down_reload();
    $display("sim passed");
    $finish;
  end

endmodule
